// File: Bender.yml
package:
  name: tile_noc

sources:
  - source/noc_pkg.sv
  - source/flit_fifo.sv
  - source/rr_arbiter.sv
  - source/inject_stage.sv
  - source/x_router.sv
  - source/tile_noc.sv
  - target: test
    files:
      - verif/tb_tile_noc.sv

// File: list.f
source/noc_pkg.sv
source/flit_fifo.sv
source/rr_arbiter.sv
source/inject_stage.sv
source/x_router.sv
source/tile_noc.sv
verif/tb_tile_noc.sv

// File: source/flit_fifo.sv
`timescale 1ns/10ps

module flit_fifo
  #(parameter int fifo_els_p = 2
    , parameter type flit_t = logic
    )
   (input                clk_i
    , input              rst_i

    , input  flit_t      data_i
    , input              v_i
    , output logic       ready_o

    , output flit_t      data_o
    , output logic       v_o
    , input              yumi_i
    );

   localparam int ptr_width_lp = $clog2(fifo_els_p);
   localparam int cnt_width_lp = $clog2(fifo_els_p + 1);

   flit_t                   mem_r [fifo_els_p];
   logic [ptr_width_lp-1:0] wptr_r;
   logic [ptr_width_lp-1:0] rptr_r;
   logic [cnt_width_lp-1:0] count_r;
   logic                    wr_en;
   logic                    rd_en;

   function automatic logic [ptr_width_lp-1:0] next_ptr(logic [ptr_width_lp-1:0] ptr);
      if (ptr == ptr_width_lp'(fifo_els_p - 1))
         return '0;
      else
         return ptr + 1'b1;
   endfunction

   assign ready_o = (count_r != cnt_width_lp'(fifo_els_p));
   assign v_o     = (count_r != '0);
   assign data_o  = mem_r[rptr_r];

   assign wr_en = v_i & ready_o;
   assign rd_en = yumi_i & v_o;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         wptr_r  <= '0;
         rptr_r  <= '0;
         count_r <= '0;
      end
      else
      begin
         if (wr_en)
            wptr_r <= next_ptr(wptr_r);
         if (rd_en)
            rptr_r <= next_ptr(rptr_r);
         if (wr_en && !rd_en)
            count_r <= count_r + 1'b1;
         else if (rd_en && !wr_en)
            count_r <= count_r - 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (wr_en)
         mem_r[wptr_r] <= data_i;
   end

   // Router only pops a head that is there
   assert property (@(posedge clk_i) disable iff (rst_i) yumi_i |-> v_o);

   // Refused flit stays offered until the FIFO takes it
   assert property (@(posedge clk_i) disable iff (rst_i)
                    (v_i && !ready_o) |=> (v_i && $stable(data_i)));

endmodule

// File: source/inject_stage.sv
`timescale 1ns/10ps

module inject_stage
  #(parameter type payload_t = noc_pkg::req_payload_t
    , parameter type flit_t = noc_pkg::req_flit_t
    )
   (input                     clk_i
    , input                   rst_i

    , input  payload_t        payload_i
    , input  noc_pkg::x_cord_t dst_i
    , input                   v_i
    , output logic            ready_o

    , output flit_t           flit_o
    , output logic            v_o
    , input                   ready_i
    );

   flit_t flit_r;
   logic  v_r;

   // Empty, or draining this cycle
   assign ready_o = ~v_r | ready_i;
   assign v_o     = v_r;
   assign flit_o  = flit_r;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         v_r <= 1'b0;
      else if (ready_o)
         v_r <= v_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (v_i && ready_o)
      begin
         flit_r.payload <= payload_i;
         flit_r.dst     <= dst_i;
      end
   end

endmodule

// File: source/noc_pkg.sv
package noc_pkg;

   localparam int x_cord_width_gp = 4;

   typedef logic [x_cord_width_gp-1:0] x_cord_t;

   typedef logic [31:0] req_payload_t;
   typedef logic [15:0] cmd_payload_t;

   // Header sits in the low bits, below the payload
   typedef struct packed
   {
      req_payload_t payload;
      x_cord_t      dst;
   } req_flit_t;

   typedef struct packed
   {
      cmd_payload_t payload;
      x_cord_t      dst;
   } cmd_flit_t;

   // Router port index
   typedef enum logic [1:0]
   {
      dir_p   = 2'd0,
      dir_w   = 2'd1,
      dir_e_c = 2'd2
   } dir_e;

endpackage

// File: source/rr_arbiter.sv
`timescale 1ns/10ps

module rr_arbiter
   (input                clk_i
    , input              rst_i
    , input        [2:0] reqs_i
    , output logic [2:0] grants_o
    , input              advance_i
    );

   logic [1:0] last_r;
   logic       hold_r;
   logic [2:0] held_grant_r;
   logic [2:0] search_grant;
   logic [1:0] winner;

   // Search starts one past the last winner
   always_comb
   begin
      int idx;
      search_grant = '0;
      for (int k = 1; k <= 3; k++)
      begin
         idx = (int'(last_r) + k) % 3;
         if (search_grant == '0 && reqs_i[idx])
            search_grant[idx] = 1'b1;
      end
   end

   assign grants_o = hold_r ? held_grant_r : search_grant;
   assign winner   = grants_o[2] ? 2'd2 : (grants_o[1] ? 2'd1 : 2'd0);

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         last_r       <= 2'd2;
         hold_r       <= 1'b0;
         held_grant_r <= '0;
      end
      else
      begin
         hold_r       <= (|grants_o) & ~advance_i;
         held_grant_r <= grants_o;
         if (advance_i)
            last_r <= winner;
      end
   end

   assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(grants_o));

endmodule

// File: source/tile_noc.sv
`timescale 1ns/10ps

module tile_noc
  #(parameter int fifo_els_p = 2
    )
   (input                                         clk_i
    , input                                       rst_i
    , input  noc_pkg::x_cord_t                    my_x_i

    // Request network
    , input  noc_pkg::req_payload_t               req_inj_payload_i
    , input  [noc_pkg::x_cord_width_gp-1:0]       req_inj_dst_i
    , input                                       req_inj_v_i
    , output logic                                req_inj_ready_o

    , output noc_pkg::req_payload_t               req_ej_payload_o
    , output logic                                req_ej_v_o
    , input                                       req_ej_ready_i

    , input  noc_pkg::req_flit_t                  req_w_link_i
    , input                                       req_w_v_i
    , output logic                                req_w_ready_o
    , output noc_pkg::req_flit_t                  req_w_link_o
    , output logic                                req_w_v_o
    , input                                       req_w_ready_i

    , input  noc_pkg::req_flit_t                  req_e_link_i
    , input                                       req_e_v_i
    , output logic                                req_e_ready_o
    , output noc_pkg::req_flit_t                  req_e_link_o
    , output logic                                req_e_v_o
    , input                                       req_e_ready_i

    // Command network
    , input  noc_pkg::cmd_payload_t               cmd_inj_payload_i
    , input  [noc_pkg::x_cord_width_gp-1:0]       cmd_inj_dst_i
    , input                                       cmd_inj_v_i
    , output logic                                cmd_inj_ready_o

    , output noc_pkg::cmd_payload_t               cmd_ej_payload_o
    , output logic                                cmd_ej_v_o
    , input                                       cmd_ej_ready_i

    , input  noc_pkg::cmd_flit_t                  cmd_w_link_i
    , input                                       cmd_w_v_i
    , output logic                                cmd_w_ready_o
    , output noc_pkg::cmd_flit_t                  cmd_w_link_o
    , output logic                                cmd_w_v_o
    , input                                       cmd_w_ready_i

    , input  noc_pkg::cmd_flit_t                  cmd_e_link_i
    , input                                       cmd_e_v_i
    , output logic                                cmd_e_ready_o
    , output noc_pkg::cmd_flit_t                  cmd_e_link_o
    , output logic                                cmd_e_v_o
    , input                                       cmd_e_ready_i
    );

   import noc_pkg::*;

   req_flit_t req_inj_flit;
   logic      req_inj_flit_v;
   logic      req_inj_flit_ready;
   req_flit_t req_ej_flit;

   cmd_flit_t cmd_inj_flit;
   logic      cmd_inj_flit_v;
   logic      cmd_inj_flit_ready;
   cmd_flit_t cmd_ej_flit;

   // Eject drops the header
   assign req_ej_payload_o = req_ej_flit.payload;
   assign cmd_ej_payload_o = cmd_ej_flit.payload;

   inject_stage
    #(.payload_t(req_payload_t)
      ,.flit_t(req_flit_t)
      )
    req_inject
     (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.payload_i(req_inj_payload_i)
      ,.dst_i(req_inj_dst_i)
      ,.v_i(req_inj_v_i)
      ,.ready_o(req_inj_ready_o)
      ,.flit_o(req_inj_flit)
      ,.v_o(req_inj_flit_v)
      ,.ready_i(req_inj_flit_ready)
      );

   x_router
    #(.fifo_els_p(fifo_els_p)
      ,.flit_t(req_flit_t)
      )
    req_router
     (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.my_x_i(my_x_i)
      ,.p_data_i(req_inj_flit)
      ,.p_v_i(req_inj_flit_v)
      ,.p_ready_o(req_inj_flit_ready)
      ,.p_data_o(req_ej_flit)
      ,.p_v_o(req_ej_v_o)
      ,.p_ready_i(req_ej_ready_i)
      ,.w_data_i(req_w_link_i)
      ,.w_v_i(req_w_v_i)
      ,.w_ready_o(req_w_ready_o)
      ,.w_data_o(req_w_link_o)
      ,.w_v_o(req_w_v_o)
      ,.w_ready_i(req_w_ready_i)
      ,.e_data_i(req_e_link_i)
      ,.e_v_i(req_e_v_i)
      ,.e_ready_o(req_e_ready_o)
      ,.e_data_o(req_e_link_o)
      ,.e_v_o(req_e_v_o)
      ,.e_ready_i(req_e_ready_i)
      );

   inject_stage
    #(.payload_t(cmd_payload_t)
      ,.flit_t(cmd_flit_t)
      )
    cmd_inject
     (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.payload_i(cmd_inj_payload_i)
      ,.dst_i(cmd_inj_dst_i)
      ,.v_i(cmd_inj_v_i)
      ,.ready_o(cmd_inj_ready_o)
      ,.flit_o(cmd_inj_flit)
      ,.v_o(cmd_inj_flit_v)
      ,.ready_i(cmd_inj_flit_ready)
      );

   x_router
    #(.fifo_els_p(fifo_els_p)
      ,.flit_t(cmd_flit_t)
      )
    cmd_router
     (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.my_x_i(my_x_i)
      ,.p_data_i(cmd_inj_flit)
      ,.p_v_i(cmd_inj_flit_v)
      ,.p_ready_o(cmd_inj_flit_ready)
      ,.p_data_o(cmd_ej_flit)
      ,.p_v_o(cmd_ej_v_o)
      ,.p_ready_i(cmd_ej_ready_i)
      ,.w_data_i(cmd_w_link_i)
      ,.w_v_i(cmd_w_v_i)
      ,.w_ready_o(cmd_w_ready_o)
      ,.w_data_o(cmd_w_link_o)
      ,.w_v_o(cmd_w_v_o)
      ,.w_ready_i(cmd_w_ready_i)
      ,.e_data_i(cmd_e_link_i)
      ,.e_v_i(cmd_e_v_i)
      ,.e_ready_o(cmd_e_ready_o)
      ,.e_data_o(cmd_e_link_o)
      ,.e_v_o(cmd_e_v_o)
      ,.e_ready_i(cmd_e_ready_i)
      );

endmodule

// File: source/x_router.sv
`timescale 1ns/10ps

module x_router
  #(parameter int fifo_els_p = 2
    , parameter type flit_t = noc_pkg::req_flit_t
    )
   (input                      clk_i
    , input                    rst_i
    , input  noc_pkg::x_cord_t my_x_i

    , input  flit_t            p_data_i
    , input                    p_v_i
    , output logic             p_ready_o
    , output flit_t            p_data_o
    , output logic             p_v_o
    , input                    p_ready_i

    , input  flit_t            w_data_i
    , input                    w_v_i
    , output logic             w_ready_o
    , output flit_t            w_data_o
    , output logic             w_v_o
    , input                    w_ready_i

    , input  flit_t            e_data_i
    , input                    e_v_i
    , output logic             e_ready_o
    , output flit_t            e_data_o
    , output logic             e_v_o
    , input                    e_ready_i
    );

   import noc_pkg::*;

   localparam int ports_lp = 3;

   flit_t               in_data [ports_lp];
   logic [ports_lp-1:0] in_v;
   logic [ports_lp-1:0] in_ready;

   flit_t               head_data [ports_lp];
   logic [ports_lp-1:0] head_v;
   logic [ports_lp-1:0] head_yumi;
   dir_e                head_dir [ports_lp];

   logic [ports_lp-1:0] out_reqs [ports_lp];
   logic [ports_lp-1:0] out_grants [ports_lp];
   flit_t               out_data [ports_lp];
   logic [ports_lp-1:0] out_v;
   logic [ports_lp-1:0] out_ready;
   logic [ports_lp-1:0] out_advance;

   function automatic dir_e route_f(x_cord_t dst, x_cord_t my_x);
      if (dst == my_x)
         return dir_p;
      else if (dst > my_x)
         return dir_e_c;
      else
         return dir_w;
   endfunction

   // Bit order follows the dir_e values
   assign in_data[dir_p]   = p_data_i;
   assign in_data[dir_w]   = w_data_i;
   assign in_data[dir_e_c] = e_data_i;
   assign in_v             = {e_v_i, w_v_i, p_v_i};
   assign out_ready        = {e_ready_i, w_ready_i, p_ready_i};

   assign p_ready_o = in_ready[dir_p];
   assign w_ready_o = in_ready[dir_w];
   assign e_ready_o = in_ready[dir_e_c];

   assign p_data_o = out_data[dir_p];
   assign w_data_o = out_data[dir_w];
   assign e_data_o = out_data[dir_e_c];
   assign p_v_o    = out_v[dir_p];
   assign w_v_o    = out_v[dir_w];
   assign e_v_o    = out_v[dir_e_c];

   for (genvar i = 0; i < ports_lp; i++)
   begin : g_in
      flit_fifo
       #(.fifo_els_p(fifo_els_p)
         ,.flit_t(flit_t)
         )
       fifo
        (.clk_i(clk_i)
         ,.rst_i(rst_i)
         ,.data_i(in_data[i])
         ,.v_i(in_v[i])
         ,.ready_o(in_ready[i])
         ,.data_o(head_data[i])
         ,.v_o(head_v[i])
         ,.yumi_i(head_yumi[i])
         );

      assign head_dir[i] = route_f(head_data[i].dst, my_x_i);
   end

   for (genvar o = 0; o < ports_lp; o++)
   begin : g_out
      for (genvar i = 0; i < ports_lp; i++)
      begin : g_req
         assign out_reqs[o][i] = head_v[i] && (head_dir[i] == dir_e'(o));
      end

      rr_arbiter arb
        (.clk_i(clk_i)
         ,.rst_i(rst_i)
         ,.reqs_i(out_reqs[o])
         ,.grants_o(out_grants[o])
         ,.advance_i(out_advance[o])
         );

      assign out_v[o]       = |out_grants[o];
      assign out_advance[o] = out_v[o] & out_ready[o];

      always_comb
      begin
         out_data[o] = head_data[0];
         for (int i = 0; i < ports_lp; i++)
         begin
            if (out_grants[o][i])
               out_data[o] = head_data[i];
         end
      end
   end

   // Winner leaves its FIFO when its output takes the flit
   always_comb
   begin
      head_yumi = '0;
      for (int o = 0; o < ports_lp; o++)
         head_yumi = head_yumi | (out_grants[o] & {ports_lp{out_advance[o]}});
   end

   // Neighbour routers never send a flit back where it came from
   assert property (@(posedge clk_i) disable iff (rst_i)
                    head_v[dir_w] |-> (head_dir[dir_w] != dir_w));
   assert property (@(posedge clk_i) disable iff (rst_i)
                    head_v[dir_e_c] |-> (head_dir[dir_e_c] != dir_e_c));

endmodule

// File: verif/tb_tile_noc.sv
`timescale 1ns/10ps

module tb_tile_noc;

   // Port index k = net*3 + port, net 0 req / 1 cmd, port 0 P / 1 W / 2 E
   logic        clk_i;
   logic        rst_i;
   logic [35:0] in_data [6];
   logic [5:0]  in_v;
   wire  [5:0]  in_ready;
   wire  [35:0] out_data [6];
   wire  [5:0]  out_v;
   logic [5:0]  out_ready;
   int          stall_cnt [6];

   int          vsrc [$];
   logic [35:0] vflit [$];
   int          vstall [$];
   int          vout [$];
   string       exp_name [$];
   int          exp_port [$];
   int          exp_src [$];
   logic [35:0] exp_val [$];

   assign out_data[0][35:32] = '0;
   assign out_data[3][35:16] = '0;
   assign out_data[4][35:20] = '0;
   assign out_data[5][35:20] = '0;

   tile_noc #(.fifo_els_p(2)) DUT
     (.clk_i(clk_i), .rst_i(rst_i), .my_x_i(4'd4)
      ,.req_inj_payload_i(in_data[0][35:4]), .req_inj_dst_i(in_data[0][3:0])
      ,.req_inj_v_i(in_v[0]), .req_inj_ready_o(in_ready[0])
      ,.req_ej_payload_o(out_data[0][31:0]), .req_ej_v_o(out_v[0])
      ,.req_ej_ready_i(out_ready[0])
      ,.req_w_link_i(in_data[1]), .req_w_v_i(in_v[1]), .req_w_ready_o(in_ready[1])
      ,.req_w_link_o(out_data[1]), .req_w_v_o(out_v[1]), .req_w_ready_i(out_ready[1])
      ,.req_e_link_i(in_data[2]), .req_e_v_i(in_v[2]), .req_e_ready_o(in_ready[2])
      ,.req_e_link_o(out_data[2]), .req_e_v_o(out_v[2]), .req_e_ready_i(out_ready[2])
      ,.cmd_inj_payload_i(in_data[3][19:4]), .cmd_inj_dst_i(in_data[3][3:0])
      ,.cmd_inj_v_i(in_v[3]), .cmd_inj_ready_o(in_ready[3])
      ,.cmd_ej_payload_o(out_data[3][15:0]), .cmd_ej_v_o(out_v[3])
      ,.cmd_ej_ready_i(out_ready[3])
      ,.cmd_w_link_i(in_data[4][19:0]), .cmd_w_v_i(in_v[4]), .cmd_w_ready_o(in_ready[4])
      ,.cmd_w_link_o(out_data[4][19:0]), .cmd_w_v_o(out_v[4]), .cmd_w_ready_i(out_ready[4])
      ,.cmd_e_link_i(in_data[5][19:0]), .cmd_e_v_i(in_v[5]), .cmd_e_ready_o(in_ready[5])
      ,.cmd_e_link_o(out_data[5][19:0]), .cmd_e_v_o(out_v[5]), .cmd_e_ready_i(out_ready[5])
      );

   always #20 clk_i = ~clk_i;

   function automatic string port_name(int k);
      return {(k < 3) ? "req" : "cmd",
              (k % 3 == 0) ? " local port" : ((k % 3 == 1) ? " west link" : " east link")};
   endfunction

   task automatic fail_run(string msg);
      $display("%s", msg);
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic compare(string name, logic [35:0] exp, logic [35:0] act);
      if (act !== exp)
         fail_run($sformatf("[FAIL] test %s expected %h actual %h", name, exp, act));
   endtask

   task automatic read_vectors();
      int          fd;
      int          n;
      int          net;
      int          src;
      int          dst;
      int          stall;
      int          outp;
      logic [31:0] payload;
      string       line;
      string       name;
      fd = $fopen("verif/tile_noc_vectors.txt", "r");
      if (fd == 0)
         fail_run("Could not open verif/tile_noc_vectors.txt");
      while (!$feof(fd))
      begin
         line = "";
         n = $fgets(line, fd);
         if (n > 0 && line[0] != "#")
         begin
            n = $sscanf(line, "%s %d %d %d %h %d %d", name, net, src, dst, payload, stall, outp);
            if (n == 7)
            begin
               vsrc.push_back(net * 3 + src);
               vflit.push_back({payload, dst[3:0]});
               vstall.push_back(stall);
               vout.push_back(net * 3 + outp);
               exp_name.push_back(name);
               exp_port.push_back(net * 3 + outp);
               exp_src.push_back(src);
               // Eject carries the payload alone
               exp_val.push_back((outp == 0) ? {4'h0, payload} : {payload, dst[3:0]});
            end
         end
      end
      $fclose(fd);
      if (vsrc.size() == 0)
         fail_run("The vector file holds no packets");
   endtask

   // Sends every vector of one input in file order
   task automatic send_port(int k);
      int t;
      bit accepted;
      for (int i = 0; i < vsrc.size(); i++)
      begin
         if (vsrc[i] == k)
         begin
            @(negedge clk_i);
            in_data[k] = vflit[i];
            in_v[k]    = 1'b1;
            accepted   = 1'b0;
            for (t = 0; t < 200 && !accepted; t++)
            begin
               @(posedge clk_i);
               accepted = in_ready[k];
            end
            if (!accepted)
               fail_run($sformatf("Timeout: %s never accepted a flit", port_name(k)));
            if (vstall[i] > 0)
               stall_cnt[vout[i]] = vstall[i];
         end
      end
      @(negedge clk_i);
      in_v[k] = 1'b0;
   endtask

   task automatic drive_ready();
      forever
      begin
         @(negedge clk_i);
         for (int k = 0; k < 6; k++)
         begin
            if (stall_cnt[k] > 0)
            begin
               out_ready[k] = 1'b0;
               stall_cnt[k] = stall_cnt[k] - 1;
            end
            else
               out_ready[k] = ($urandom % 8) != 0;
         end
      end
   endtask

   // Accepts the head of any source queue, so each source keeps its own order
   task automatic take_flit(int k, logic [35:0] act);
      int       hit;
      int       first;
      int       idx;
      bit [2:0] seen;
      hit   = -1;
      first = -1;
      seen  = '0;
      for (int i = 0; i < exp_val.size(); i++)
      begin
         if (exp_port[i] == k && !seen[exp_src[i]])
         begin
            seen[exp_src[i]] = 1'b1;
            if (first < 0)
               first = i;
            if (hit < 0 && exp_val[i] == act)
               hit = i;
         end
      end
      if (first < 0)
         fail_run($sformatf("Unexpected flit %h on %s", act, port_name(k)));
      idx = (hit >= 0) ? hit : first;
      compare(exp_name[idx], exp_val[idx], act);
      exp_name.delete(idx);
      exp_port.delete(idx);
      exp_src.delete(idx);
      exp_val.delete(idx);
   endtask

   always @(posedge clk_i)
   begin
      if (!rst_i)
      begin
         for (int k = 0; k < 6; k++)
            if (out_v[k] && out_ready[k])
               take_flit(k, out_data[k]);
      end
   end

   initial
   begin
      int t;
      void'($urandom(32'h36959f5f));
      clk_i     = 1'b0;
      rst_i     = 1'b1;
      in_v      = '0;
      out_ready = '0;
      for (int k = 0; k < 6; k++)
      begin
         in_data[k]   = '0;
         stall_cnt[k] = 0;
      end
      read_vectors();
      fork
         drive_ready();
      join_none
      repeat (8) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;

      for (int k = 0; k < 6; k++)
         compare("reset_idle", 36'h0, {35'h0, out_v[k]});
      t = 0;
      while (!(&in_ready) && t < 200)
      begin
         @(posedge clk_i);
         t++;
      end
      if (!(&in_ready))
         fail_run("Timeout: an input port kept ready low after reset");

      fork
         send_port(0);
         send_port(1);
         send_port(2);
         send_port(3);
         send_port(4);
         send_port(5);
      join

      t = 0;
      while (exp_val.size() != 0 && t < 200)
      begin
         @(posedge clk_i);
         t++;
      end
      if (exp_val.size() == 0)
      begin
         $display("Regression passed");
         $finish;
      end
      else
         fail_run($sformatf("Timeout: %s never delivered the flit of test %s",
                            port_name(exp_port[0]), exp_name[0]));
   end

endmodule

// File: verif/tile_noc_vectors.txt
# name net(0 req, 1 cmd) src(0 P, 1 W, 2 E) dst payload(hex) stall out(0 P, 1 W, 2 E)
# out is the port that the routing rule picks for dst with my_x = 4
basic_eject  0 0 4 a0000001 0 0
basic_east   0 0 7 a0000002 0 2
basic_west   0 0 1 a0000003 0 1
pass_east    0 1 9 b0000001 0 2
link_eject   0 1 4 b0000002 0 0
link_west    0 2 0 c0000001 0 1
merge_east   0 0 6 a0000020 0 2
merge_east   0 1 8 b0000020 0 2
merge_east   0 0 6 a0000021 0 2
merge_east   0 1 8 b0000021 0 2
merge_east   0 0 5 a0000022 3 2
merge_east   0 1 15 b0000022 0 2
stall_eject  0 0 4 a0000010 12 0
stall_eject  0 0 4 a0000011 0 0
stall_eject  0 0 4 a0000012 0 0
stall_eject  0 0 4 a0000013 0 0
cmd_eject    1 0 4 1001 5 0
cmd_east     1 0 10 1002 0 2
cmd_west     1 2 2 3001 0 1
cmd_eject_e  1 2 4 3002 0 0
cmd_pass     1 1 5 2001 0 2
